/* logic/wisc_pkg.sv */
/* Shared types for the 16-bit WISC pipeline core: opcodes, instruction formats,
   control and flag bundles. Imported by every RTL block of the core. */
package wisc_pkg;

    // Machine widths fixed by the ISA
    localparam int unsigned XLEN   = 16;
    localparam int unsigned REG_AW = 4;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        OP_ADD  = 4'h0, OP_SUB = 4'h1, OP_XOR = 4'h2, OP_RED = 4'h3,
        OP_SLL  = 4'h4, OP_SRA = 4'h5, OP_ROR = 4'h6, OP_PADDSB = 4'h7,
        OP_LW   = 4'h8, OP_SW  = 4'h9, OP_LLB = 4'hA, OP_LHB = 4'hB,
        OP_B    = 4'hC, OP_BR  = 4'hD, OP_PCS = 4'hE, OP_HLT = 4'hF
    } opcode_e;

    typedef enum logic [2:0] {
        COND_NE = 3'b000, COND_EQ = 3'b001, COND_GT = 3'b010, COND_LT = 3'b011,
        COND_GE = 3'b100, COND_LE = 3'b101, COND_OV = 3'b110, COND_UN = 3'b111
    } cond_e;

    // ------------------------------
    // Instruction word, two views
    // ------------------------------
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;     // Also shift amount and memory offset
    } instr_reg_t;

    typedef struct packed {
        opcode_e    opcode;
        cond_e      cond;
        logic [8:0] offset;  // Signed, in half-words
    } instr_ctl_t;

    typedef union packed {
        instr_reg_t r;
        instr_ctl_t c;
    } instr_u;

    typedef struct packed {
        logic zero;
        logic overflow;
        logic sign;
    } flags_t;

    typedef struct packed {
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       alu_src;
        logic       llb;
        logic       lhb;
        logic       branch;
        logic       branch_reg;
        logic       pcs;
        logic       halt;
        logic [2:0] flag_en;  // Zero, overflow, sign
    } ctrl_t;

    // Execute stage results for the write-back register
    typedef struct packed {
        logic       valid;
        reg_idx_t   dst;
        logic       reg_write;
        logic       halt;
        word_t      alu_out;
        word_t      link;
        logic       use_link;
        logic       use_load;
        flags_t     flags;
        logic [2:0] flag_en;
    } ex_result_t;

    // RED opcode decodes to an all-zero control word
    localparam word_t NOP_INSTR = 16'h3000;

endpackage

/* logic/control_unit.sv */
/* Opcode decoder for the execute stage, purely combinational.
   Unsupported opcodes decode to an all-zero control word. */
`timescale 1ns/1ns

module control_unit (
    input  wisc_pkg::opcode_e opcode,
    output wisc_pkg::ctrl_t   ctrl
);
    import wisc_pkg::*;

    always_comb begin
        ctrl = '0;
        unique case (opcode)
            // Arithmetic sets all three flags
            OP_ADD, OP_SUB: begin
                ctrl.reg_write = 1'b1;
                ctrl.flag_en   = 3'b111;
            end
            OP_XOR: begin
                ctrl.reg_write = 1'b1;
                ctrl.flag_en   = 3'b100;
            end
            // Shift amount comes from the immediate
            OP_SLL, OP_SRA, OP_ROR: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.flag_en   = 3'b100;
            end
            OP_LW: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            OP_SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            OP_LLB: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.llb       = 1'b1;
            end
            OP_LHB: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.lhb       = 1'b1;
            end
            OP_B:   ctrl.branch = 1'b1;
            OP_BR:  ctrl.branch_reg = 1'b1;
            OP_PCS: begin
                ctrl.reg_write = 1'b1;
                ctrl.pcs       = 1'b1;
            end
            OP_HLT: ctrl.halt = 1'b1;
            // RED, PADDSB
            default: ctrl = '0;
        endcase
    end

endmodule

/* logic/register_file.sv */
/* Sixteen general registers, two read ports and one write port.
   Same-cycle writes bypass to the readers; register 0 reads zero. */
`timescale 1ns/1ns

module register_file (
    input  logic              clk,
    input  logic              rst_n,
    input  wisc_pkg::reg_idx_t rs_a,
    input  wisc_pkg::reg_idx_t rs_b,
    input  wisc_pkg::reg_idx_t dst,
    input  logic              wen,
    input  wisc_pkg::word_t   wdata,
    output wisc_pkg::word_t   rdata_a,
    output wisc_pkg::word_t   rdata_b
);
    import wisc_pkg::*;

    word_t regs [2**REG_AW];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[dst] <= wdata;
        end
    end

    // Write-before-read
    assign rdata_a = (rs_a == '0) ? '0 : (wen && dst == rs_a) ? wdata : regs[rs_a];
    assign rdata_b = (rs_b == '0) ? '0 : (wen && dst == rs_b) ? wdata : regs[rs_b];

endmodule

/* logic/alu_16bit.sv */
/* Execute-stage ALU: saturating add/sub, logic, shifts, byte loads and
   load/store address generation, plus zero/overflow/sign flags. */
`timescale 1ns/1ns

module alu_16bit (
    input  wisc_pkg::word_t   a,
    input  wisc_pkg::word_t   b,
    input  wisc_pkg::opcode_e op,
    input  wisc_pkg::ctrl_t   ctrl,
    output wisc_pkg::word_t   result,
    output wisc_pkg::flags_t  flags
);
    import wisc_pkg::*;

    logic        is_sub;
    word_t       b_eff;
    word_t       sum;
    logic        ovf;
    logic        ovf_out;
    logic [3:0]  shamt;
    logic [31:0] rot;

    // ------------------------------
    // Shared adder
    // ------------------------------
    assign is_sub = (op == OP_SUB);
    // Subtract as a + ~b + 1
    assign b_eff  = is_sub ? ~b : b;
    assign sum    = a + b_eff + {15'd0, is_sub};
    // Same input signs, different result sign
    assign ovf    = (a[15] == b_eff[15]) && (sum[15] != a[15]);

    assign shamt = b[3:0];
    // Rotate via doubled word
    assign rot   = {a, a} >> shamt;

    always_comb begin
        ovf_out = 1'b0;
        if (ctrl.mem_read || ctrl.mem_write) begin
            // Half-word aligned base plus offset in half-words
            result = {a[15:1], 1'b0} + {b[14:0], 1'b0};
        end else if (ctrl.llb) begin
            result = {a[15:8], b[7:0]};
        end else if (ctrl.lhb) begin
            result = {b[7:0], a[7:0]};
        end else begin
            unique case (op)
                OP_ADD, OP_SUB: begin
                    // Clamp toward the sign of a
                    result  = ovf ? (a[15] ? 16'h8000 : 16'h7FFF) : sum;
                    ovf_out = ovf;
                end
                OP_XOR:  result = a ^ b;
                OP_SLL:  result = a << shamt;
                OP_SRA:  result = word_t'($signed(a) >>> shamt);
                OP_ROR:  result = rot[15:0];
                default: result = '0;
            endcase
        end
    end

    assign flags.zero     = (result == '0);
    assign flags.overflow = ovf_out;
    assign flags.sign     = result[15];

endmodule

/* logic/pc_control.sv */
/* Branch resolution in execute: condition test against the flag register,
   next PC, redirect request and PCS link value. */
`timescale 1ns/1ns

module pc_control (
    input  wisc_pkg::instr_u instr,
    input  wisc_pkg::ctrl_t  ctrl,
    input  wisc_pkg::flags_t flags,
    input  wisc_pkg::word_t  pc_plus_two,
    input  wisc_pkg::word_t  target_reg,
    output wisc_pkg::word_t  next_pc,
    output logic             redirect,
    output wisc_pkg::word_t  link
);
    import wisc_pkg::*;

    word_t offset_ext;
    logic  cond_ok;

    // Sign-extended half-word offset
    assign offset_ext = {{6{instr.c.offset[8]}}, instr.c.offset, 1'b0};

    always_comb begin
        cond_ok = 1'b1;
        case (instr.c.cond)
            COND_NE: cond_ok = !flags.zero;
            COND_EQ: cond_ok = flags.zero;
            COND_GT: cond_ok = !flags.zero && !flags.sign;
            COND_LT: cond_ok = flags.sign;
            COND_GE: cond_ok = flags.zero || !flags.sign;
            COND_LE: cond_ok = flags.sign || flags.zero;
            COND_OV: cond_ok = flags.overflow;
            default: cond_ok = 1'b1;
        endcase
    end

    // PCS and HLT always redirect, branches only when taken
    assign redirect = ((ctrl.branch || ctrl.branch_reg) && cond_ok) || ctrl.pcs || ctrl.halt;
    assign link     = pc_plus_two;

    always_comb begin
        if (ctrl.halt) begin
            next_pc = pc_plus_two - 16'd2;  // Stay on the HLT
        end else if (ctrl.branch_reg) begin
            next_pc = target_reg;
        end else if (ctrl.pcs) begin
            next_pc = pc_plus_two;
        end else begin
            next_pc = pc_plus_two + offset_ext;
        end
    end

endmodule

/* logic/ex_wb_pipe.sv */
/* Execute/write-back register. Picks the write-back value, holds the flag
   register and the sticky halt; a stall or invalid input becomes a bubble. */
`timescale 1ns/1ns

module ex_wb_pipe (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  wisc_pkg::ex_result_t ex,
    input  wisc_pkg::word_t      load_data,
    output logic                 wen,
    output wisc_pkg::reg_idx_t   dst,
    output wisc_pkg::word_t      wdata,
    output wisc_pkg::flags_t     flags,
    output logic                 hlt
);
    import wisc_pkg::*;

    logic  commit;
    word_t result;

    // Instruction leaves execute this cycle
    assign commit = ex.valid && !stall;

    assign result = ex.use_link ? ex.link :
                    ex.use_load ? load_data : ex.alu_out;

    // ------------------------------
    // Control state
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wen   <= 1'b0;
            flags <= '0;
            hlt   <= 1'b0;
        end else begin
            wen <= commit && ex.reg_write;
            // Only enabled flag bits change
            if (commit) begin
                flags <= (flags & ~ex.flag_en) | (ex.flags & ex.flag_en);
            end
            if (commit && ex.halt) begin
                hlt <= 1'b1;
            end
        end
    end

    // Payload, qualified by wen
    always_ff @(posedge clk) begin
        if (commit) begin
            dst   <= ex.dst;
            wdata <= result;
        end
    end

endmodule

/* logic/cpu.sv */
/* Top level of the three-stage WISC core: PC, fetch register, operand
   forwarding and the Wishbone classic data master. */
`timescale 1ns/1ns

module cpu (
    input  logic            clk,
    input  logic            rst_n,
    input  wisc_pkg::word_t instr,
    output wisc_pkg::word_t pc,
    output logic            hlt,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we,
    output wisc_pkg::word_t wb_adr,
    output wisc_pkg::word_t wb_dat_o,
    input  wisc_pkg::word_t wb_dat_i,
    input  logic            wb_ack
);
    import wisc_pkg::*;

    word_t      pc_plus_two;
    instr_u     if_instr;
    word_t      if_pc_plus_two;
    ctrl_t      ctrl;
    reg_idx_t   src_a;
    reg_idx_t   src_b;
    word_t      rf_a;
    word_t      rf_b;
    word_t      op_a;
    word_t      op_b;
    word_t      imm;
    word_t      alu_b;
    word_t      alu_out;
    flags_t     alu_flags;
    word_t      next_pc;
    word_t      link;
    logic       redirect;
    logic       mem_access;
    logic       stall;
    ex_result_t ex;
    logic       wb_wen;
    reg_idx_t   wb_dst;
    word_t      wb_wdata;
    flags_t     flag_reg;

    // ------------------------------
    // Fetch
    // ------------------------------
    assign pc_plus_two = pc + 16'd2;

    // Hold on stall and after halt
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (!stall && !hlt) begin
            pc <= redirect ? next_pc : pc_plus_two;
        end
    end

    // Bubble on redirect or halt
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_instr       <= NOP_INSTR;
            if_pc_plus_two <= '0;
        end else if (!stall) begin
            if_instr       <= (redirect || hlt) ? NOP_INSTR : instr;
            if_pc_plus_two <= pc_plus_two;
        end
    end

    // ------------------------------
    // Execute
    // ------------------------------
    control_unit u_ctrl (.opcode(if_instr.r.opcode), .ctrl(ctrl));

    // Byte loads modify rd, stores write rd out
    assign src_a = (ctrl.llb || ctrl.lhb) ? if_instr.r.rd : if_instr.r.rs;
    assign src_b = ctrl.mem_write ? if_instr.r.rd : if_instr.r.rt;

    register_file u_rf (
        .clk(clk), .rst_n(rst_n),
        .rs_a(src_a), .rs_b(src_b),
        .dst(wb_dst), .wen(wb_wen), .wdata(wb_wdata),
        .rdata_a(rf_a), .rdata_b(rf_b)
    );

    // Write-back result reaches the operands through the register file bypass
    assign op_a = rf_a;
    assign op_b = rf_b;

    always_comb begin
        if (ctrl.llb || ctrl.lhb) begin
            imm = {8'h00, if_instr[7:0]};
        end else if (ctrl.mem_read || ctrl.mem_write) begin
            imm = {{12{if_instr.r.rt[3]}}, if_instr.r.rt};
        end else begin
            imm = {12'h000, if_instr.r.rt};
        end
    end

    assign alu_b = ctrl.alu_src ? imm : op_b;

    alu_16bit u_alu (
        .a(op_a), .b(alu_b), .op(if_instr.r.opcode), .ctrl(ctrl),
        .result(alu_out), .flags(alu_flags)
    );

    pc_control u_pcc (
        .instr(if_instr), .ctrl(ctrl), .flags(flag_reg),
        .pc_plus_two(if_pc_plus_two), .target_reg(op_a),
        .next_pc(next_pc), .redirect(redirect), .link(link)
    );

    // Wishbone master, held by the stall until ack
    assign mem_access = ctrl.mem_read || ctrl.mem_write;
    assign wb_cyc     = mem_access;
    assign wb_stb     = mem_access;
    assign wb_we      = ctrl.mem_write;
    assign wb_adr     = alu_out;
    assign wb_dat_o   = op_b;
    assign stall      = mem_access && !wb_ack;

    always_comb begin
        ex.valid     = (ctrl != '0);
        ex.dst       = if_instr.r.rd;
        ex.reg_write = ctrl.reg_write;
        ex.halt      = ctrl.halt;
        ex.alu_out   = alu_out;
        ex.link      = link;
        ex.use_link  = ctrl.pcs;
        ex.use_load  = ctrl.mem_read;
        ex.flags     = alu_flags;
        ex.flag_en   = ctrl.flag_en;
    end

    // ------------------------------
    // Write-back
    // ------------------------------
    ex_wb_pipe u_exwb (
        .clk(clk), .rst_n(rst_n), .stall(stall),
        .ex(ex), .load_data(wb_dat_i),
        .wen(wb_wen), .dst(wb_dst), .wdata(wb_wdata),
        .flags(flag_reg), .hlt(hlt)
    );

endmodule

/* tests/cpu_properties.sv */
/* Concurrent checks on the Wishbone data port and the halt output.
   Bound into every cpu instance by the bind at the end of this file. */
`timescale 1ns/1ns

module cpu_properties (
    input logic            clk,
    input logic            rst_n,
    input logic            hlt,
    input wisc_pkg::word_t pc,
    input logic            wb_cyc,
    input logic            wb_stb,
    input logic            wb_we,
    input wisc_pkg::word_t wb_adr,
    input wisc_pkg::word_t wb_dat_o,
    input logic            wb_ack
);
    import wisc_pkg::*;

    // Strobe only inside a cycle
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
        else $error("wb_stb high while wb_cyc is low");

    // Request held steady through wait states
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) && $stable(wb_dat_o)
                                 && $stable(wb_we)))
        else $error("Wishbone request changed before ack");

    a_hlt_sticky: assert property (@(posedge clk) disable iff (!rst_n) hlt |=> hlt)
        else $error("hlt fell without reset");

    a_pc_frozen: assert property (@(posedge clk) disable iff (!rst_n) hlt |=> $stable(pc))
        else $error("pc moved while halted");

endmodule

bind cpu cpu_properties u_props (.*);

/* tests/cpu_tb.sv */
/* Directed testbench for the cpu core: instruction ROM and Wishbone data
   memory models, one task per feature, store log and halt PC checks. */
`timescale 1ns/1ns

module cpu_tb;
    import wisc_pkg::*;

    localparam int CYCLE_LIMIT = 3000;

    logic       clk;
    logic       rst_n;
    word_t      instr;
    word_t      pc;
    logic       hlt;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    word_t      wb_adr;
    word_t      wb_dat_o;
    word_t      wb_dat_i;
    logic       wb_ack;

    word_t      imem [256];
    word_t      dmem [256];
    word_t      prog_q[$];
    word_t      st_adr[$];
    word_t      st_dat[$];
    word_t      exp_adr[$];
    word_t      exp_dat[$];
    word_t      halt_addr;
    logic [1:0] wait_cnt;
    logic [1:0] wait_lim;
    int         cycles;
    int         checks;
    int         errors;

    cpu dut_i (
        .clk(clk), .rst_n(rst_n), .instr(instr), .pc(pc), .hlt(hlt),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
    );

    always #50 clk = ~clk;

    // ------------------------------
    // Memory models
    // ------------------------------
    // Same-cycle instruction fetch
    assign instr = imem[pc[8:1]];

    // Ack once the random wait count is reached, zero waits allowed
    assign wb_ack   = wb_cyc && wb_stb && (wait_cnt == wait_lim);
    assign wb_dat_i = dmem[wb_adr[8:1]];

    always @(posedge clk) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (wb_ack) begin
            wait_cnt <= '0;
            wait_lim <= 2'($urandom % 4);
            if (wb_we) begin
                dmem[wb_adr[8:1]] <= wb_dat_o;
                st_adr.push_back(wb_adr);
                st_dat.push_back(wb_dat_o);
            end
        end else if (wb_cyc && wb_stb) begin
            wait_cnt <= wait_cnt + 2'd1;
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: core did not halt within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    // ------------------------------
    // Program building
    // ------------------------------
    function automatic word_t enc_r(opcode_e op, logic [3:0] rd, logic [3:0] rs,
                                    logic [3:0] rt);
        return {op, rd, rs, rt};
    endfunction

    function automatic word_t enc_b(logic [2:0] cond, logic [8:0] off);
        return {OP_B, cond, off};
    endfunction

    task automatic emit(word_t w);
        prog_q.push_back(w);
    endtask

    task automatic set_reg(logic [3:0] r, word_t value);
        emit(enc_r(OP_LLB, r, value[7:4], value[3:0]));
        emit(enc_r(OP_LHB, r, value[15:12], value[11:8]));
    endtask

    task automatic emit_halt();
        halt_addr = word_t'(2 * prog_q.size());
        emit({OP_HLT, 12'h000});
    endtask

    task automatic expect_store(word_t adr, word_t dat);
        exp_adr.push_back(adr);
        exp_dat.push_back(dat);
    endtask

    // Saturating add/sub as the ISA defines it
    function automatic word_t sat_arith(word_t a, word_t b, logic sub);
        int s;
        s = sub ? int'($signed(a)) - int'($signed(b)) : int'($signed(a)) + int'($signed(b));
        if (s > 32767) s = 32767;
        if (s < -32768) s = -32768;
        return word_t'(s);
    endfunction

    // Branch condition table, judged on the signed result
    function automatic logic cond_taken(logic [2:0] c, int res, logic v);
        case (c)
            3'b000:  return res != 0;
            3'b001:  return res == 0;
            3'b010:  return res > 0;
            3'b011:  return res < 0;
            3'b100:  return res >= 0;
            3'b101:  return res <= 0;
            3'b110:  return v;
            default: return 1'b1;
        endcase
    endfunction

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic check_word(string what, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_pc(word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: halt pc got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_count(string what, int got, int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // Load, reset, wait for halt, compare the store log
    task automatic run_program(string name);
        int n;
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < prog_q.size()) ? prog_q[i] : {4'hF, 4'h0, 8'(i)};
            dmem[i] = 16'h0100 + word_t'(i);
        end
        st_adr.delete();
        st_dat.delete();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        while (!hlt) @(posedge clk);
        repeat (2) @(posedge clk);
        check_pc(pc, halt_addr);
        if (!hlt) begin
            errors++;
            $display("%s: hlt did not stay high after the halt", name);
        end
        check_count({name, " store count"}, st_adr.size(), exp_adr.size());
        n = (st_adr.size() < exp_adr.size()) ? st_adr.size() : exp_adr.size();
        for (int i = 0; i < n; i++) begin
            check_word({name, " store address"}, st_adr[i], exp_adr[i]);
            check_word({name, " store data"}, st_dat[i], exp_dat[i]);
        end
        prog_q.delete();
        exp_adr.delete();
        exp_dat.delete();
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic test_arith();
        set_reg(1, 16'h7000);
        set_reg(2, 16'h2000);
        set_reg(4, 16'h8000);
        emit(enc_r(OP_ADD, 3, 1, 2));
        emit(enc_r(OP_SW, 3, 0, 0));
        emit(enc_r(OP_SUB, 5, 4, 2));
        emit(enc_r(OP_SW, 5, 0, 1));
        emit(enc_r(OP_ADD, 6, 2, 2));
        emit(enc_r(OP_SUB, 7, 6, 1));
        emit(enc_r(OP_SW, 6, 0, 2));
        emit(enc_r(OP_SW, 7, 0, 3));
        emit_halt();
        expect_store(16'h0000, sat_arith(16'h7000, 16'h2000, 1'b0));
        expect_store(16'h0002, sat_arith(16'h8000, 16'h2000, 1'b1));
        expect_store(16'h0004, sat_arith(16'h2000, 16'h2000, 1'b0));
        expect_store(16'h0006, sat_arith(16'h4000, 16'h7000, 1'b1));
        run_program("arith");
    endtask

    task automatic test_logic();
        set_reg(1, 16'h1234);
        set_reg(2, 16'h00FF);
        set_reg(6, 16'hF00F);
        emit(enc_r(OP_XOR, 3, 1, 2));
        emit(enc_r(OP_SLL, 4, 1, 4));
        emit(enc_r(OP_SRA, 5, 6, 4));
        emit(enc_r(OP_ROR, 7, 1, 4));
        emit(enc_r(OP_SW, 3, 0, 0));
        emit(enc_r(OP_SW, 4, 0, 1));
        emit(enc_r(OP_SW, 5, 0, 2));
        emit(enc_r(OP_SW, 7, 0, 3));
        emit(enc_r(OP_SW, 1, 0, 4));
        emit_halt();
        expect_store(16'h0000, 16'h12CB);
        expect_store(16'h0002, 16'h2340);
        expect_store(16'h0004, 16'hFF00);
        expect_store(16'h0006, 16'h4123);
        expect_store(16'h0008, 16'h1234);
        run_program("logic");
    endtask

    // Odd base clears bit 0, offsets count half-words
    task automatic test_load_use();
        set_reg(1, 16'h0041);
        emit(enc_r(OP_LW, 2, 1, 1));
        emit(enc_r(OP_ADD, 3, 2, 2));
        emit(enc_r(OP_SW, 3, 1, 4'hF));
        emit(enc_r(OP_LW, 4, 1, 2));
        emit(enc_r(OP_SW, 4, 1, 3));
        emit_halt();
        expect_store(16'h003E, sat_arith(16'h0121, 16'h0121, 1'b0));
        expect_store(16'h0046, 16'h0122);
        run_program("load_use");
    endtask

    task automatic test_branches();
        int   res [4];
        logic v [4];
        logic [7:0] id;
        // 5-5, 0-5, 5+5, and 7000h+7000h saturated
        res = '{0, -5, 10, 32767};
        v   = '{1'b0, 1'b0, 1'b0, 1'b1};
        set_reg(1, 16'h0005);
        set_reg(4, 16'h7000);
        for (int s = 0; s < 4; s++) begin
            for (int c = 0; c < 8; c++) begin
                id = 8'(s * 8 + c);
                emit(enc_r(OP_LLB, 9, id[7:4], id[3:0]));
                case (s)
                    0:       emit(enc_r(OP_SUB, 3, 1, 1));
                    1:       emit(enc_r(OP_SUB, 3, 0, 1));
                    2:       emit(enc_r(OP_ADD, 3, 1, 1));
                    default: emit(enc_r(OP_ADD, 3, 4, 4));
                endcase
                // Skip the store when taken
                emit(enc_b(3'(c), 9'd1));
                emit(enc_r(OP_SW, 9, 0, 0));
                if (!cond_taken(3'(c), res[s], v[s])) begin
                    expect_store(16'h0000, {8'h00, id});
                end
            end
        end
        emit_halt();
        run_program("branches");
    endtask

    task automatic test_br_pcs();
        emit(enc_r(OP_LLB, 7, 4'h7, 4'h7));
        emit(enc_r(OP_LLB, 6, 4'h0, 4'hC));
        emit({OP_BR, 3'b111, 1'b0, 4'd6, 4'h0});
        emit(enc_r(OP_SW, 7, 0, 0));
        emit(enc_r(OP_SW, 7, 0, 1));
        emit({OP_HLT, 12'h000});
        // Branch target, byte address 0x0C
        emit(enc_r(OP_PCS, 5, 0, 0));
        emit(enc_r(OP_SW, 5, 0, 2));
        emit_halt();
        expect_store(16'h0004, 16'h000E);
        run_program("br_pcs");
    endtask

    // XOR leaves overflow alone, SUB clears it
    task automatic test_flag_hold();
        set_reg(4, 16'h7000);
        set_reg(1, 16'h00F0);
        set_reg(2, 16'h000F);
        emit(enc_r(OP_ADD, 3, 4, 4));
        emit(enc_r(OP_XOR, 5, 1, 2));
        emit(enc_b(3'b110, 9'd1));
        emit(enc_r(OP_SW, 5, 0, 0));
        emit(enc_r(OP_SUB, 3, 1, 1));
        emit(enc_b(3'b110, 9'd1));
        emit(enc_r(OP_SW, 5, 0, 1));
        emit_halt();
        expect_store(16'h0002, 16'h00FF);
        run_program("flag_hold");
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        cycles   = 0;
        checks   = 0;
        errors   = 0;
        wait_cnt = '0;
        wait_lim = '0;
        void'($urandom(32'he66b_a481));
        test_arith();
        test_logic();
        test_load_use();
        test_branches();
        test_br_pcs();
        test_flag_hold();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* compile.f */
logic/wisc_pkg.sv
logic/control_unit.sv
logic/register_file.sv
logic/alu_16bit.sv
logic/pc_control.sv
logic/ex_wb_pipe.sv
logic/cpu.sv
tests/cpu_properties.sv
tests/cpu_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator and run; pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb \
    -f compile.f -o cpu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/cpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" sim.log; then
    exit 0
fi
exit 1
